// ==== verilog/llc_geometry_pkg.sv ====
package llc_geometry_pkg;

    // default cache geometry, the top level can override each of these

    // ways per set
    parameter int default_num_ways = 4;

    // set index width, 64 sets
    parameter int default_set_bits = 6;

    // tag stored per way
    parameter int default_tag_bits = 12;

    // data line stored per way
    parameter int default_line_bits = 32;

    // width of a way index, also used for the eviction pointer
    parameter int default_way_bits = $clog2(default_num_ways);

endpackage

// ==== verilog/llc_coherence_pkg.sv ====
package llc_coherence_pkg;

    // width of a stored coherence state
    parameter int llc_state_bits = 3;

    // per-way coherence state
    // invalid must stay at zero, reset and flush both rely on it
    typedef enum logic [llc_state_bits-1:0] {
        invalid      = 3'd0,
        valid        = 3'd1,
        shared_state = 3'd2,
        exclusive    = 3'd3,
        modified     = 3'd4,
        // shared with a pending downgrade
        sd           = 3'd5,
        dirty_state  = 3'd6
    } llc_state_e;

    // the other per-way fields
    //   dirty bit   line differs from memory
    //   tag         upper address bits of the cached line
    //   line        cached data
    // per set
    //   evict way   next way to replace in that set

endpackage

// ==== verilog/llc_write_decode.sv ====
`timescale 1ns/100ps

module llc_write_decode #(
    parameter int num_ways  = llc_geometry_pkg::default_num_ways,
    parameter int way_bits  = llc_geometry_pkg::default_way_bits,
    parameter int set_bits  = llc_geometry_pkg::default_set_bits,
    parameter int tag_bits  = llc_geometry_pkg::default_tag_bits,
    parameter int line_bits = llc_geometry_pkg::default_line_bits
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [set_bits-1:0]           set_in,
    input  logic [way_bits-1:0]           way,
    input  logic                          rd_en,
    input  logic                          wr_en,
    input  logic [num_ways-1:0]           wr_rst_flush,
    input  logic                          wr_en_evict_way,
    input  llc_coherence_pkg::llc_state_e wr_data_state,
    input  logic                          wr_data_dirty_bit,
    input  logic [tag_bits-1:0]           wr_data_tag,
    input  logic [line_bits-1:0]          wr_data_line,
    input  logic [way_bits-1:0]           wr_data_evict_way,
    output logic [set_bits-1:0]           set_q,
    output logic                          rd_q,
    output logic [num_ways-1:0]           meta_we,
    output logic [num_ways-1:0]           data_we,
    output logic                          evict_we_q,
    output llc_coherence_pkg::llc_state_e state_q,
    output logic                          dirty_q,
    output logic [tag_bits-1:0]           tag_q,
    output logic [line_bits-1:0]          line_q,
    output logic [way_bits-1:0]           evict_way_q
);

    logic [num_ways-1:0] meta_we_d;
    logic [num_ways-1:0] data_we_d;

    // target way gets everything and flushed ways only state and dirty
    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            data_we_d[i] = wr_en && (way == way_bits'(i));
            meta_we_d[i] = data_we_d[i] || wr_rst_flush[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_q       <= 1'b0;
            meta_we    <= '0;
            data_we    <= '0;
            evict_we_q <= 1'b0;
        end else begin
            rd_q       <= rd_en;
            meta_we    <= meta_we_d;
            data_we    <= data_we_d;
            evict_we_q <= wr_en_evict_way;
        end
    end

    // request payload is only meaningful alongside the enables above
    always_ff @(posedge clk) begin
        set_q       <= set_in;
        state_q     <= wr_data_state;
        dirty_q     <= wr_data_dirty_bit;
        tag_q       <= wr_data_tag;
        line_q      <= wr_data_line;
        evict_way_q <= wr_data_evict_way;
    end

    a_way_in_range: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (way < num_ways))
        else $error("write targets way %0d beyond num_ways", way);

    // a write reaches at most one way's tag and line in stage two
    a_data_we_onehot: assert property (@(posedge clk) disable iff (reset)
        wr_en |=> $onehot0(data_we))
        else $error("data_we not one-hot after a write: %b", data_we);

endmodule

// ==== verilog/llc_way_array.sv ====
`timescale 1ns/100ps

module llc_way_array #(
    parameter int set_bits  = llc_geometry_pkg::default_set_bits,
    parameter int tag_bits  = llc_geometry_pkg::default_tag_bits,
    parameter int line_bits = llc_geometry_pkg::default_line_bits
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [set_bits-1:0]           set_q,
    input  logic                          rd_q,
    input  logic                          meta_we,
    input  logic                          data_we,
    input  llc_coherence_pkg::llc_state_e state_q,
    input  logic                          dirty_q,
    input  logic [tag_bits-1:0]           tag_q,
    input  logic [line_bits-1:0]          line_q,
    output llc_coherence_pkg::llc_state_e rd_state,
    output logic                          rd_dirty,
    output logic [tag_bits-1:0]           rd_tag,
    output logic [line_bits-1:0]          rd_line
);

    import llc_coherence_pkg::*;

    localparam int num_sets = 1 << set_bits;

    // one entry per set for this way
    llc_state_e           state_mem [num_sets];
    logic                 dirty_mem [num_sets];
    logic [tag_bits-1:0]  tag_mem   [num_sets];
    logic [line_bits-1:0] line_mem  [num_sets];

    // meta fields also take flush writes
    always_ff @(posedge clk) begin
        if (meta_we) begin
            state_mem[set_q] <= state_q;
            dirty_mem[set_q] <= dirty_q;
        end
    end

    always_ff @(posedge clk) begin
        if (data_we) begin
            tag_mem[set_q]  <= tag_q;
            line_mem[set_q] <= line_q;
        end
    end

    // read-first: same-edge writes land after these reads sample the arrays
    // outputs hold while rd_q is low
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_state <= invalid;
            rd_dirty <= 1'b0;
            rd_tag   <= '0;
            rd_line  <= '0;
        end else if (rd_q) begin
            rd_state <= state_mem[set_q];
            rd_dirty <= dirty_mem[set_q];
            rd_tag   <= tag_mem[set_q];
            rd_line  <= line_mem[set_q];
        end
    end

    // tag and line are never written without the meta fields of the same way
    a_data_implies_meta: assert property (@(posedge clk) disable iff (reset)
        data_we |-> meta_we)
        else $error("tag/line write without state/dirty write at set %0d", set_q);

endmodule

// ==== verilog/llc_evict_array.sv ====
`timescale 1ns/100ps

module llc_evict_array #(
    parameter int set_bits = llc_geometry_pkg::default_set_bits,
    parameter int way_bits = llc_geometry_pkg::default_way_bits
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [set_bits-1:0] set_q,
    input  logic                rd_q,
    input  logic                evict_we_q,
    input  logic [way_bits-1:0] evict_way_q,
    output logic [way_bits-1:0] rd_evict_way
);

    localparam int num_sets = 1 << set_bits;

    // replacement pointer per set
    logic [way_bits-1:0] evict_mem [num_sets];

    always_ff @(posedge clk) begin
        if (evict_we_q) begin
            evict_mem[set_q] <= evict_way_q;
        end
    end

    // old pointer on a same-cycle write, held while rd_q is low
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_evict_way <= '0;
        end else if (rd_q) begin
            rd_evict_way <= evict_mem[set_q];
        end
    end

endmodule

// ==== verilog/llc_localmem.sv ====
`timescale 1ns/100ps

module llc_localmem #(
    parameter int num_ways  = llc_geometry_pkg::default_num_ways,
    parameter int set_bits  = llc_geometry_pkg::default_set_bits,
    parameter int tag_bits  = llc_geometry_pkg::default_tag_bits,
    parameter int line_bits = llc_geometry_pkg::default_line_bits,
    parameter int way_bits  = llc_geometry_pkg::default_way_bits
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [set_bits-1:0]           set_in,
    input  logic [way_bits-1:0]           way,
    input  logic                          rd_en,
    input  logic                          wr_en,
    input  logic [num_ways-1:0]           wr_rst_flush,
    input  logic                          wr_en_evict_way,
    input  llc_coherence_pkg::llc_state_e wr_data_state,
    input  logic                          wr_data_dirty_bit,
    input  logic [tag_bits-1:0]           wr_data_tag,
    input  logic [line_bits-1:0]          wr_data_line,
    input  logic [way_bits-1:0]           wr_data_evict_way,
    output llc_coherence_pkg::llc_state_e rd_data_state     [num_ways],
    output logic                          rd_data_dirty_bit [num_ways],
    output logic [tag_bits-1:0]           rd_data_tag       [num_ways],
    output logic [line_bits-1:0]          rd_data_line      [num_ways],
    output logic [way_bits-1:0]           rd_data_evict_way
);

    import llc_coherence_pkg::*;

    // stage one to stage two
    logic [set_bits-1:0]  set_q;
    logic                 rd_q;
    logic [num_ways-1:0]  meta_we;
    logic [num_ways-1:0]  data_we;
    logic                 evict_we_q;
    llc_state_e           state_q;
    logic                 dirty_q;
    logic [tag_bits-1:0]  tag_q;
    logic [line_bits-1:0] line_q;
    logic [way_bits-1:0]  evict_way_q;

    llc_write_decode #(
        .num_ways  (num_ways),
        .way_bits  (way_bits),
        .set_bits  (set_bits),
        .tag_bits  (tag_bits),
        .line_bits (line_bits)
    ) i_write_decode (
        .clk               (clk),
        .reset             (reset),
        .set_in            (set_in),
        .way               (way),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_state     (wr_data_state),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_tag       (wr_data_tag),
        .wr_data_line      (wr_data_line),
        .wr_data_evict_way (wr_data_evict_way),
        .set_q             (set_q),
        .rd_q              (rd_q),
        .meta_we           (meta_we),
        .data_we           (data_we),
        .evict_we_q        (evict_we_q),
        .state_q           (state_q),
        .dirty_q           (dirty_q),
        .tag_q             (tag_q),
        .line_q            (line_q),
        .evict_way_q       (evict_way_q)
    );

    for (genvar i = 0; i < num_ways; i++) begin : g_way
        llc_way_array #(
            .set_bits  (set_bits),
            .tag_bits  (tag_bits),
            .line_bits (line_bits)
        ) i_way_array (
            .clk      (clk),
            .reset    (reset),
            .set_q    (set_q),
            .rd_q     (rd_q),
            .meta_we  (meta_we[i]),
            .data_we  (data_we[i]),
            .state_q  (state_q),
            .dirty_q  (dirty_q),
            .tag_q    (tag_q),
            .line_q   (line_q),
            .rd_state (rd_data_state[i]),
            .rd_dirty (rd_data_dirty_bit[i]),
            .rd_tag   (rd_data_tag[i]),
            .rd_line  (rd_data_line[i])
        );
    end

    llc_evict_array #(
        .set_bits (set_bits),
        .way_bits (way_bits)
    ) i_evict_array (
        .clk          (clk),
        .reset        (reset),
        .set_q        (set_q),
        .rd_q         (rd_q),
        .evict_we_q   (evict_we_q),
        .evict_way_q  (evict_way_q),
        .rd_evict_way (rd_data_evict_way)
    );

endmodule

// ==== test/llc_localmem_checker.sv ====
`timescale 1ns/100ps

module llc_localmem_checker #(
    parameter int num_ways  = llc_geometry_pkg::default_num_ways,
    parameter int set_bits  = llc_geometry_pkg::default_set_bits,
    parameter int tag_bits  = llc_geometry_pkg::default_tag_bits,
    parameter int line_bits = llc_geometry_pkg::default_line_bits,
    parameter int way_bits  = llc_geometry_pkg::default_way_bits
) (
    input logic                          clk,
    input logic                          reset,
    input logic [set_bits-1:0]           set_in,
    input logic [way_bits-1:0]           way,
    input logic                          rd_en,
    input logic                          wr_en,
    input logic [num_ways-1:0]           wr_rst_flush,
    input logic                          wr_en_evict_way,
    input llc_coherence_pkg::llc_state_e wr_data_state,
    input logic                          wr_data_dirty_bit,
    input logic [tag_bits-1:0]           wr_data_tag,
    input logic [line_bits-1:0]          wr_data_line,
    input logic [way_bits-1:0]           wr_data_evict_way,
    input llc_coherence_pkg::llc_state_e rd_data_state     [num_ways],
    input logic                          rd_data_dirty_bit [num_ways],
    input logic [tag_bits-1:0]           rd_data_tag       [num_ways],
    input logic [line_bits-1:0]          rd_data_line      [num_ways],
    input logic [way_bits-1:0]           rd_data_evict_way
);

    import llc_coherence_pkg::*;

    localparam int num_sets = 1 << set_bits;

    // model contents, X until first written
    llc_state_e           state_m [num_sets][num_ways];
    logic                 dirty_m [num_sets][num_ways];
    logic [tag_bits-1:0]  tag_m   [num_sets][num_ways];
    logic [line_bits-1:0] line_m  [num_sets][num_ways];
    logic [way_bits-1:0]  evict_m [num_sets];

    // two-deep queue: pend_* sampled last edge, exp_* now on the outputs
    llc_state_e           pend_state [num_ways];
    logic                 pend_dirty [num_ways];
    logic [tag_bits-1:0]  pend_tag   [num_ways];
    logic [line_bits-1:0] pend_line  [num_ways];
    logic [way_bits-1:0]  pend_evict;
    llc_state_e           exp_state  [num_ways];
    logic                 exp_dirty  [num_ways];
    logic [tag_bits-1:0]  exp_tag    [num_ways];
    logic [line_bits-1:0] exp_line   [num_ways];
    logic [way_bits-1:0]  exp_evict;
    logic                 pend_rd = 1'b0;
    logic                 exp_fresh = 1'b0;
    logic                 armed = 1'b0;
    int                   errors = 0;
    int                   checks = 0;
    int                   reads_open = 0;

    // fields never written are skipped
    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (^expected === 1'bx) begin
            return;
        end
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t", name, expected, actual, $time);
        end
    endtask

    always @(posedge clk) begin
        if (armed) begin
            for (int w = 0; w < num_ways; w++) begin
                check_field($sformatf("rd_data_state[%0d]", w), exp_state[w], rd_data_state[w]);
                check_field($sformatf("rd_data_dirty_bit[%0d]", w), exp_dirty[w],
                            rd_data_dirty_bit[w]);
                check_field($sformatf("rd_data_tag[%0d]", w), exp_tag[w], rd_data_tag[w]);
                check_field($sformatf("rd_data_line[%0d]", w), exp_line[w], rd_data_line[w]);
            end
            check_field("rd_data_evict_way", exp_evict, rd_data_evict_way);
            if (exp_fresh) begin
                reads_open--;
            end
            exp_fresh = 1'b0;
        end
        if (reset) begin
            armed = 1'b1;
            pend_rd = 1'b0;
            exp_state = '{default: invalid};
            exp_dirty = '{default: 1'b0};
            exp_tag = '{default: '0};
            exp_line = '{default: '0};
            exp_evict = '0;
        end else begin
            if (pend_rd) begin
                exp_state = pend_state;
                exp_dirty = pend_dirty;
                exp_tag = pend_tag;
                exp_line = pend_line;
                exp_evict = pend_evict;
                exp_fresh = 1'b1;
            end
            // read taken before this cycle's write lands
            pend_rd = rd_en;
            if (rd_en) begin
                reads_open++;
                pend_state = state_m[set_in];
                pend_dirty = dirty_m[set_in];
                pend_tag = tag_m[set_in];
                pend_line = line_m[set_in];
                pend_evict = evict_m[set_in];
            end
            for (int w = 0; w < num_ways; w++) begin
                if ((wr_en && way == w) || wr_rst_flush[w]) begin
                    state_m[set_in][w] = wr_data_state;
                    dirty_m[set_in][w] = wr_data_dirty_bit;
                end
                if (wr_en && way == w) begin
                    tag_m[set_in][w] = wr_data_tag;
                    line_m[set_in][w] = wr_data_line;
                end
            end
            if (wr_en_evict_way) begin
                evict_m[set_in] = wr_data_evict_way;
            end
        end
    end

endmodule

// ==== test/tb_llc_localmem.sv ====
`timescale 1ns/100ps

module tb_llc_localmem;

    import llc_geometry_pkg::*;
    import llc_coherence_pkg::*;

    localparam int num_ways  = default_num_ways;
    localparam int set_bits  = default_set_bits;
    localparam int tag_bits  = default_tag_bits;
    localparam int line_bits = default_line_bits;
    localparam int way_bits  = default_way_bits;
    localparam int num_sets  = 1 << set_bits;

    logic                 clk;
    logic                 reset;
    logic [set_bits-1:0]  set_in;
    logic [way_bits-1:0]  way;
    logic                 rd_en;
    logic                 wr_en;
    logic [num_ways-1:0]  wr_rst_flush;
    logic                 wr_en_evict_way;
    llc_state_e           wr_data_state;
    logic                 wr_data_dirty_bit;
    logic [tag_bits-1:0]  wr_data_tag;
    logic [line_bits-1:0] wr_data_line;
    logic [way_bits-1:0]  wr_data_evict_way;
    llc_state_e           rd_data_state     [num_ways];
    logic                 rd_data_dirty_bit [num_ways];
    logic [tag_bits-1:0]  rd_data_tag       [num_ways];
    logic [line_bits-1:0] rd_data_line      [num_ways];
    logic [way_bits-1:0]  rd_data_evict_way;

    logic [31:0] lfsr = 32'h50ea;
    int          passed_tests = 0;
    int          failed_tests = 0;
    int          errors_before = 0;
    logic [set_bits-1:0] same_set;

    llc_localmem #(
        .num_ways  (num_ways),
        .set_bits  (set_bits),
        .tag_bits  (tag_bits),
        .line_bits (line_bits),
        .way_bits  (way_bits)
    ) i_llc_localmem (.*);

    llc_localmem_checker #(
        .num_ways  (num_ways),
        .set_bits  (set_bits),
        .tag_bits  (tag_bits),
        .line_bits (line_bits),
        .way_bits  (way_bits)
    ) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        rd_en = 1'b0;
        wr_en = 1'b0;
        wr_rst_flush = '0;
        wr_en_evict_way = 1'b0;
    endtask

    task automatic random_request(input logic do_wr, input logic do_flush, input logic do_evict);
        set_in = set_bits'(take_bits(set_bits));
        way = way_bits'(take_bits(way_bits));
        rd_en = 1'(take_bits(1));
        wr_en = do_wr;
        wr_rst_flush = do_flush ? num_ways'(take_bits(num_ways)) : '0;
        wr_en_evict_way = do_evict;
        wr_data_state = llc_state_e'(3'(take_bits(3) % 7));
        wr_data_dirty_bit = 1'(take_bits(1));
        wr_data_tag = tag_bits'(take_bits(tag_bits));
        wr_data_line = line_bits'(take_bits(line_bits));
        wr_data_evict_way = way_bits'(take_bits(way_bits));
    endtask

    task automatic read_all_sets();
        for (int s = 0; s < num_sets; s++) begin
            idle();
            rd_en = 1'b1;
            set_in = set_bits'(s);
            next_cycle();
        end
    endtask

    // wait until every read issued has been compared
    task automatic end_test(input string name);
        int waited;
        int new_errors;
        waited = 0;
        idle();
        while (i_checker.reads_open != 0 && waited < 10) begin
            next_cycle();
            waited++;
        end
        new_errors = i_checker.errors - errors_before;
        errors_before = i_checker.errors;
        if (i_checker.reads_open != 0) begin
            failed_tests++;
            $display("test %s: timed out waiting for read data to come back", name);
        end else if (new_errors != 0) begin
            failed_tests++;
            $display("test %s: failed with %0d mismatches", name, new_errors);
        end else begin
            passed_tests++;
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        reset = 1'b1;
        idle();
        set_in = '0;
        way = '0;
        wr_data_state = invalid;
        wr_data_dirty_bit = 1'b0;
        wr_data_tag = '0;
        wr_data_line = '0;
        wr_data_evict_way = '0;
        repeat (8) next_cycle();
        reset = 1'b0;

        for (int s = 0; s < num_sets; s++) begin
            idle();
            set_in = set_bits'(s);
            wr_rst_flush = '1;
            wr_data_state = invalid;
            wr_data_dirty_bit = 1'b0;
            next_cycle();
        end
        read_all_sets();
        end_test("flush");

        repeat (200) begin
            random_request(1'b1, 1'b0, 1'b0);
            next_cycle();
        end
        read_all_sets();
        end_test("random writes");

        repeat (150) begin
            random_request(1'b1, 1'b1, 1'b0);
            next_cycle();
        end
        read_all_sets();
        end_test("flush with write");

        repeat (150) begin
            random_request(1'(take_bits(1)), 1'(take_bits(1)), 1'b1);
            next_cycle();
        end
        read_all_sets();
        end_test("eviction pointer");

        // one read then writes with rd_en low while the outputs hold
        random_request(1'b0, 1'b0, 1'b0);
        rd_en = 1'b1;
        next_cycle();
        repeat (50) begin
            random_request(1'b1, 1'(take_bits(1)), 1'(take_bits(1)));
            rd_en = 1'b0;
            next_cycle();
        end
        end_test("read enable");

        repeat (32) begin
            random_request(1'b1, 1'(take_bits(1)), 1'(take_bits(1)));
            rd_en = 1'b1;
            same_set = set_in;
            next_cycle();
            idle();
            rd_en = 1'b1;
            set_in = same_set;
            next_cycle();
        end
        end_test("same-cycle read and write");

        $display("%0d tests passed, %0d failed, %0d values checked, %0d mismatches",
                 passed_tests, failed_tests, i_checker.checks, i_checker.errors);
        if (failed_tests == 0 && i_checker.errors == 0 && i_checker.checks > 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
verilog/llc_geometry_pkg.sv
verilog/llc_coherence_pkg.sv
verilog/llc_write_decode.sv
verilog/llc_way_array.sv
verilog/llc_evict_array.sv
verilog/llc_localmem.sv
test/llc_localmem_checker.sv
test/tb_llc_localmem.sv
